// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;

    // 9 single-bit controls plus the 4-bit aluop, jr is decoded on its own
    localparam int ctrl_width = 13;

    localparam logic [5:0] op_rtype = 6'b000000;
    localparam logic [5:0] op_lw    = 6'b100011;
    localparam logic [5:0] op_sw    = 6'b101011;
    localparam logic [5:0] op_beq   = 6'b000100;
    localparam logic [5:0] op_bne   = 6'b000101;
    localparam logic [5:0] op_addi  = 6'b001000;
    localparam logic [5:0] op_addiu = 6'b001001;
    localparam logic [5:0] op_andi  = 6'b001100;
    localparam logic [5:0] op_ori   = 6'b001101;
    localparam logic [5:0] op_xori  = 6'b001110;
    localparam logic [5:0] op_slti  = 6'b001010;
    localparam logic [5:0] op_lui   = 6'b001111;
    localparam logic [5:0] op_j     = 6'b000010;
    localparam logic [5:0] op_jal   = 6'b000011;

    localparam logic [5:0] funct_add = 6'b100000;
    localparam logic [5:0] funct_sub = 6'b100010;
    localparam logic [5:0] funct_and = 6'b100100;
    localparam logic [5:0] funct_or  = 6'b100101;
    localparam logic [5:0] funct_slt = 6'b101010;
    localparam logic [5:0] funct_jr  = 6'b001000;

    localparam logic [3:0] aluop_add   = 4'd0;
    localparam logic [3:0] aluop_sub   = 4'd1;
    localparam logic [3:0] aluop_and   = 4'd2;
    localparam logic [3:0] aluop_or    = 4'd3;
    localparam logic [3:0] aluop_xor   = 4'd4;
    localparam logic [3:0] aluop_slt   = 4'd5;
    localparam logic [3:0] aluop_lui   = 4'd6;
    localparam logic [3:0] aluop_funct = 4'd7; // look at funct field

    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_or  = 4'd3;
    localparam logic [3:0] alu_xor = 4'd4;
    localparam logic [3:0] alu_slt = 4'd5;
    localparam logic [3:0] alu_lui = 4'd6;

endpackage

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [mips_pkg::data_width-1:0] a,
    input  logic [mips_pkg::data_width-1:0] b,
    input  logic [3:0]                      alu_control,
    output logic [mips_pkg::data_width-1:0] result,
    output logic                            zero
);

    logic less; // signed compare

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (alu_control)
            mips_pkg::alu_add:
                result = a + b;
            mips_pkg::alu_sub:
                result = a - b;
            mips_pkg::alu_and:
                result = a & b;
            mips_pkg::alu_or:
                result = a | b;
            mips_pkg::alu_xor:
                result = a ^ b;
            mips_pkg::alu_slt:
                result = {{(mips_pkg::data_width-1){1'b0}}, less};
            mips_pkg::alu_lui:
                result = b << 16; // immediate to upper half
            default:
                result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== rtl/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder (
    input  logic [3:0] aluop,
    input  logic [5:0] funct,
    output logic [3:0] alu_control
);

    logic [3:0] funct_control;

    // r-type field decode
    always_comb begin
        case (funct)
            mips_pkg::funct_add: funct_control = mips_pkg::alu_add;
            mips_pkg::funct_sub: funct_control = mips_pkg::alu_sub;
            mips_pkg::funct_and: funct_control = mips_pkg::alu_and;
            mips_pkg::funct_or:  funct_control = mips_pkg::alu_or;
            mips_pkg::funct_slt: funct_control = mips_pkg::alu_slt;
            default:             funct_control = mips_pkg::alu_add;
        endcase
    end

    always_comb begin
        case (aluop)
            mips_pkg::aluop_add:   alu_control = mips_pkg::alu_add;
            mips_pkg::aluop_sub:   alu_control = mips_pkg::alu_sub;
            mips_pkg::aluop_and:   alu_control = mips_pkg::alu_and;
            mips_pkg::aluop_or:    alu_control = mips_pkg::alu_or;
            mips_pkg::aluop_xor:   alu_control = mips_pkg::alu_xor;
            mips_pkg::aluop_slt:   alu_control = mips_pkg::alu_slt;
            mips_pkg::aluop_lui:   alu_control = mips_pkg::alu_lui;
            mips_pkg::aluop_funct: alu_control = funct_control;
            default:               alu_control = mips_pkg::alu_add;
        endcase
    end

endmodule

// ==== rtl/main_decoder.sv ====
`timescale 1ns/1ps

module main_decoder (
    input  logic [5:0] op,
    input  logic [5:0] funct,
    output logic       regwrite,
    output logic       regdst,
    output logic       alusrc,
    output logic       branch,
    output logic       ne,
    output logic       memwrite,
    output logic       memtoreg,
    output logic       jump,
    output logic       jr,
    output logic       link,
    output logic [3:0] aluop
);

    logic [mips_pkg::ctrl_width-1:0] controls;

    assign jr = (op == mips_pkg::op_rtype) && (funct == mips_pkg::funct_jr);

    assign {regwrite, regdst, alusrc, branch, ne, memwrite,
            memtoreg, jump, link, aluop} = controls;

    // bit order regwrite regdst alusrc branch ne memwrite memtoreg jump link
    always_comb begin
        if (jr) begin
            controls = '0; // only the pc moves
        end else begin
            case (op)
                mips_pkg::op_rtype:
                    controls = {9'b110000000, mips_pkg::aluop_funct};
                mips_pkg::op_lw:
                    controls = {9'b101000100, mips_pkg::aluop_add};
                mips_pkg::op_sw:
                    controls = {9'b001001000, mips_pkg::aluop_add};
                mips_pkg::op_beq:
                    controls = {9'b000100000, mips_pkg::aluop_sub};
                mips_pkg::op_bne:
                    controls = {9'b000110000, mips_pkg::aluop_sub};
                mips_pkg::op_addi, mips_pkg::op_addiu:
                    controls = {9'b101000000, mips_pkg::aluop_add};
                mips_pkg::op_andi:
                    controls = {9'b101000000, mips_pkg::aluop_and};
                mips_pkg::op_ori:
                    controls = {9'b101000000, mips_pkg::aluop_or};
                mips_pkg::op_xori:
                    controls = {9'b101000000, mips_pkg::aluop_xor};
                mips_pkg::op_slti:
                    controls = {9'b101000000, mips_pkg::aluop_slt};
                mips_pkg::op_lui:
                    controls = {9'b101000000, mips_pkg::aluop_lui};
                mips_pkg::op_j:
                    controls = {9'b000000010, mips_pkg::aluop_add};
                mips_pkg::op_jal:
                    controls = {9'b100000011, mips_pkg::aluop_add}; // link to r31
                default:
                    controls = '0; // unknown op acts as nop
            endcase
        end
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mips_pkg::reg_addr_width-1:0] ra1,
    input  logic [mips_pkg::reg_addr_width-1:0] ra2,
    input  logic [mips_pkg::reg_addr_width-1:0] wa,
    input  logic [mips_pkg::data_width-1:0]     wd,
    input  logic                                we,
    output logic [mips_pkg::data_width-1:0]     rd1,
    output logic [mips_pkg::data_width-1:0]     rd2
);

    logic [mips_pkg::data_width-1:0] regs [2**mips_pkg::reg_addr_width];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**mips_pkg::reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin // r0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== rtl/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            regwrite,
    input  logic                            regdst,
    input  logic                            alusrc,
    input  logic                            branch,
    input  logic                            ne,
    input  logic                            memtoreg,
    input  logic                            jump,
    input  logic                            jr,
    input  logic                            link,
    input  logic [3:0]                      alu_control,
    input  logic [mips_pkg::data_width-1:0] instr,
    input  logic [mips_pkg::data_width-1:0] data_rdata,
    output logic [mips_pkg::data_width-1:0] instr_addr,
    output logic [mips_pkg::data_width-1:0] data_addr,
    output logic [mips_pkg::data_width-1:0] data_wdata
);

    logic [mips_pkg::data_width-1:0]     pc, pc_plus4, pc_branch, pc_jump, pc_next;
    logic [mips_pkg::data_width-1:0]     imm_ext, srcb, alu_result, rd1, rd2, wd;
    logic [mips_pkg::reg_addr_width-1:0] wa;
    logic                                zero, zero_ext, take_branch;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4 = pc + 32'd4;

    // logical immediates are zero extended
    assign zero_ext = (instr[31:26] == mips_pkg::op_andi) ||
                      (instr[31:26] == mips_pkg::op_ori) ||
                      (instr[31:26] == mips_pkg::op_xori);
    assign imm_ext = zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    assign pc_branch   = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign pc_jump     = {pc_plus4[31:28], instr[25:0], 2'b00};
    assign take_branch = branch & (zero ^ ne); // ne flips the sense for bne

    always_comb begin
        if (jr) begin
            pc_next = rd1;
        end else if (jump) begin
            pc_next = pc_jump;
        end else if (take_branch) begin
            pc_next = pc_branch;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_comb begin
        if (link) begin
            wa = 5'd31; // jal return address
        end else if (regdst) begin
            wa = instr[15:11];
        end else begin
            wa = instr[20:16];
        end
    end

    assign wd   = link ? pc_plus4 : (memtoreg ? data_rdata : alu_result);
    assign srcb = alusrc ? imm_ext : rd2;

    register_file i_register_file (
        .clk (clk),
        .rst (rst),
        .ra1 (instr[25:21]),
        .ra2 (instr[20:16]),
        .wa  (wa),
        .wd  (wd),
        .we  (regwrite),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    alu i_alu (
        .a           (rd1),
        .b           (srcb),
        .alu_control (alu_control),
        .result      (alu_result),
        .zero        (zero)
    );

    assign instr_addr = pc;
    assign data_addr  = alu_result;
    assign data_wdata = rd2;

endmodule

// ==== rtl/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mips_pkg::data_width-1:0] instr,
    input  logic [mips_pkg::data_width-1:0] data_rdata,
    output logic [mips_pkg::data_width-1:0] instr_addr,
    output logic [mips_pkg::data_width-1:0] data_addr,
    output logic [mips_pkg::data_width-1:0] data_wdata,
    output logic                            data_we
);

    logic       regwrite, regdst, alusrc, branch, ne;
    logic       memtoreg, jump, jr, link;
    logic [3:0] aluop, alu_control;

    main_decoder i_main_decoder (
        .op       (instr[31:26]),
        .funct    (instr[5:0]),
        .regwrite (regwrite),
        .regdst   (regdst),
        .alusrc   (alusrc),
        .branch   (branch),
        .ne       (ne),
        .memwrite (data_we), // store strobe goes straight out
        .memtoreg (memtoreg),
        .jump     (jump),
        .jr       (jr),
        .link     (link),
        .aluop    (aluop)
    );

    alu_decoder i_alu_decoder (
        .aluop       (aluop),
        .funct       (instr[5:0]),
        .alu_control (alu_control)
    );

    datapath i_datapath (
        .clk         (clk),
        .rst         (rst),
        .regwrite    (regwrite),
        .regdst      (regdst),
        .alusrc      (alusrc),
        .branch      (branch),
        .ne          (ne),
        .memtoreg    (memtoreg),
        .jump        (jump),
        .jr          (jr),
        .link        (link),
        .alu_control (alu_control),
        .instr       (instr),
        .data_rdata  (data_rdata),
        .instr_addr  (instr_addr),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata)
    );

endmodule

// ==== test/mips_core_checker.sv ====
`timescale 1ns/1ps

module mips_core_checker (
    input logic                            clk,
    input logic                            rst,
    input logic [mips_pkg::data_width-1:0] instr,
    input logic [mips_pkg::data_width-1:0] instr_addr,
    input logic                            data_we
);

    int                              fail_count = 0;
    logic [5:0]                      op;
    logic                            redirect;
    logic [mips_pkg::data_width-1:0] pc_plus4, jump_target;

    assign op          = instr[31:26];
    assign pc_plus4    = instr_addr + 32'd4;
    assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};

    // anything that may leave the straight line
    assign redirect = (op == mips_pkg::op_beq) || (op == mips_pkg::op_bne) ||
                      (op == mips_pkg::op_j) || (op == mips_pkg::op_jal) ||
                      (op == mips_pkg::op_rtype && instr[5:0] == mips_pkg::funct_jr);

    reset_pc: assert property (@(posedge clk) $fell(rst) |-> instr_addr == '0)
        else begin
            $error("FAIL %0t: pc is not zero in the first cycle after reset", $time);
            fail_count++;
        end

    reset_no_store: assert property (@(posedge clk) rst |-> !data_we)
        else begin
            $error("FAIL %0t: store strobe active during reset", $time);
            fail_count++;
        end

    sequential_pc: assert property (@(posedge clk)
        !rst && !redirect |=> instr_addr == $past(instr_addr) + 32'd4)
        else begin
            $error("FAIL %0t: pc did not advance by 4", $time);
            fail_count++;
        end

    jump_pc: assert property (@(posedge clk)
        !rst && (op == mips_pkg::op_j || op == mips_pkg::op_jal) |=>
        instr_addr == $past(jump_target))
        else begin
            $error("FAIL %0t: jump landed off its target", $time);
            fail_count++;
        end

    // only sw may strobe, undefined opcodes included
    store_only_sw: assert property (@(posedge clk) !rst && op != mips_pkg::op_sw |-> !data_we)
        else begin
            $error("FAIL %0t: store strobe from an instruction that is not sw", $time);
            fail_count++;
        end

endmodule

// ==== test/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;

    localparam int          prog_len  = 38;
    localparam int          store_len = 15;
    localparam logic [31:0] park_addr = 32'd144; // self-jump at word 36

    logic        clk, rst, data_we, parked;
    logic [31:0] instr, data_rdata, instr_addr, data_addr, data_wdata, prev_addr;
    logic [31:0] imem [prog_len];
    logic [31:0] dmem [64];
    logic [31:0] exp_data [store_len];
    int          store_count = 0;

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
        return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    mips_core i_mips_core (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .data_rdata (data_rdata),
        .instr_addr (instr_addr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we)
    );

    bind mips_core mips_core_checker i_checker (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instr_addr (instr_addr),
        .data_we    (data_we)
    );

    assign instr      = imem[instr_addr[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (!rst && data_we) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    // stores land at 0, 4, 8 ... in program order
    always @(negedge clk) begin
        if (!rst && data_we) begin
            store_count <= store_count + 1;
            assert (store_count < store_len && data_addr == 32'(4 * store_count) &&
                    data_wdata == exp_data[store_count])
            else begin
                $display("FAIL %0t: store %0d wrote %h to address %h",
                         $time, store_count, data_wdata, data_addr);
                $display(">>> FAIL");
                $fatal(1, "unexpected store");
            end
        end
    end

    // a bound assertion that fired ends the run
    always @(negedge clk) begin
        if (i_mips_core.i_checker.fail_count != 0) begin
            $display("a bound assertion on the core failed at %0t", $time);
            $display(">>> FAIL");
            $fatal(1, "checker assertion failed");
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst       = 1'b1;
        parked    = 1'b0;
        prev_addr = '1;
        imem = '{
            itype(mips_pkg::op_addi, 0, 1, 16'd6), itype(mips_pkg::op_addi, 0, 2, 16'hfffd),
            itype(mips_pkg::op_sw, 0, 1, 16'd0),   rtype(1, 2, 3, mips_pkg::funct_add),
            itype(mips_pkg::op_sw, 0, 3, 16'd4),   rtype(1, 2, 3, mips_pkg::funct_sub),
            itype(mips_pkg::op_sw, 0, 3, 16'd8),   rtype(1, 2, 3, mips_pkg::funct_and),
            itype(mips_pkg::op_sw, 0, 3, 16'd12),  rtype(1, 2, 3, mips_pkg::funct_or),
            itype(mips_pkg::op_sw, 0, 3, 16'd16),  rtype(2, 1, 3, mips_pkg::funct_slt),
            itype(mips_pkg::op_sw, 0, 3, 16'd20),  itype(mips_pkg::op_andi, 2, 3, 16'hf0f0),
            itype(mips_pkg::op_sw, 0, 3, 16'd24),  itype(mips_pkg::op_ori, 1, 3, 16'h8000),
            itype(mips_pkg::op_sw, 0, 3, 16'd28),  itype(mips_pkg::op_xori, 2, 3, 16'h00ff),
            itype(mips_pkg::op_sw, 0, 3, 16'd32),  itype(mips_pkg::op_slti, 2, 3, 16'hfffe),
            itype(mips_pkg::op_sw, 0, 3, 16'd36),  itype(mips_pkg::op_lui, 0, 3, 16'habcd),
            itype(mips_pkg::op_sw, 0, 3, 16'd40),  itype(mips_pkg::op_lw, 0, 4, 16'd8),
            itype(mips_pkg::op_sw, 0, 4, 16'd44),  itype(mips_pkg::op_beq, 1, 2, 16'd1),
            itype(mips_pkg::op_sw, 0, 4, 16'd48),  itype(mips_pkg::op_beq, 1, 1, 16'd1),
            itype(mips_pkg::op_sw, 0, 2, 16'd48),  itype(mips_pkg::op_bne, 1, 1, 16'd1),
            itype(mips_pkg::op_sw, 0, 1, 16'd52),  itype(mips_pkg::op_bne, 1, 2, 16'd1),
            itype(mips_pkg::op_sw, 0, 2, 16'd52),  jtype(mips_pkg::op_jal, 26'd37),
            itype(mips_pkg::op_sw, 0, 31, 16'd56), 32'hfc00_0000, // undefined opcode
            jtype(mips_pkg::op_j, 26'd36),         rtype(31, 0, 0, mips_pkg::funct_jr)
        };
        exp_data = '{
            32'h6, 32'h3, 32'h9, 32'h4, 32'hffff_ffff, 32'h1, 32'hf0f0, 32'h8006,
            32'hffff_ff02, 32'h1, 32'habcd_0000, 32'h9, 32'h9, 32'h6, 32'h88
        };
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hdead_0000 ^ 32'(i);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int cycle = 0; cycle < 200 && !parked; cycle++) begin
            @(negedge clk);
            parked    = (instr_addr == prev_addr);
            prev_addr = instr_addr;
        end
        if (parked && store_count == store_len && instr_addr == park_addr &&
            i_mips_core.i_checker.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            if (!parked) begin
                $display("timeout: the core never settled on the final self-jump");
            end else begin
                $display("FAIL %0t: parked at %h after %0d of %0d stores, %0d checker errors",
                         $time, instr_addr, store_count, store_len,
                         i_mips_core.i_checker.fail_count);
            end
            $display(">>> FAIL");
            $fatal(1, "run failed");
        end
    end

endmodule

// ==== filelist.f ====
rtl/mips_pkg.sv
rtl/alu.sv
rtl/alu_decoder.sv
rtl/main_decoder.sv
rtl/register_file.sv
rtl/datapath.sv
rtl/mips_core.sv
test/mips_core_checker.sv
test/tb_mips_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mips_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_mips_core -Mdir obj_dir -o sim_mips_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mips_core +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -qx ">>> PASS" sim.log; then
    exit 0
fi
exit 1
